// ==== common/panel_pkg.sv ====
// Button levels are active low (pressed is 0); brightness steps stop at 0 and BRIGHT_MAX
package panel_pkg;

    typedef struct packed {
        logic menu;
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic sel;
        logic start;
    } buttons_t;

    typedef logic [3:0] brightness_t;

    localparam brightness_t BRIGHT_MAX   = 4'd15;
    localparam brightness_t BRIGHT_RESET = 4'd3;

    localparam int DEBOUNCE_DEPTH = 16;

    typedef logic [DEBOUNCE_DEPTH-1:0] history_t;

    // One released sample, then pressed samples, and the mirror image
    localparam history_t PRESS_PATTERN   = {1'b1, {(DEBOUNCE_DEPTH-1){1'b0}}};
    localparam history_t RELEASE_PATTERN = {1'b0, {(DEBOUNCE_DEPTH-1){1'b1}}};

    typedef logic [8:0] pwm_count_t;

    localparam pwm_count_t PWM_LAST = 9'd448; // Period of 449 cycles

endpackage

// ==== common/power_pkg.sv ====
// Thresholds are fixed for a lithium cell; ADC codes are 14 bit, 256-sample average
package power_pkg;

    typedef logic [13:0] volt_t;

    typedef struct packed {
        logic  valid;
        volt_t value;
    } adc_sample_t;

    typedef struct packed {
        logic low_battery;
        logic red;
        logic white;
    } battery_leds_t;

    // 5 ms at 8.39 MHz
    localparam int ADC_INTERVAL_CYCLES = 41946;

    typedef logic [15:0] adc_timer_t;

    localparam int AVG_SAMPLES_LOG2 = 8;

    typedef logic [21:0]               volt_sum_t;
    typedef logic [AVG_SAMPLES_LOG2:0] sample_cnt_t;

    localparam volt_t VOLT_VALID = 14'd700;  // Below this, no battery
    localparam volt_t VOLT_RED   = 14'd1182; // About 3.1 V
    localparam volt_t VOLT_FULL  = 14'd1423; // About 3.75 V

    localparam int PMIC_CHARGING_BIT = 2;

endpackage

// ==== panel/panel_input.sv ====
// Buttons are asynchronous and active low; a press needs 15 steady samples to count
`timescale 1ns/1ps

module panel_input (
    input  logic                clk,
    input  logic                reset,
    input  panel_pkg::buttons_t buttons,
    output logic                menu_disabled,
    output logic                bright_up,
    output logic                bright_down
);

    localparam int MENU  = 0;
    localparam int LEFT  = 1;
    localparam int RIGHT = 2;

    panel_pkg::buttons_t btn_meta;
    panel_pkg::buttons_t btn_sync;

    logic [2:0]                       tracked;
    logic [2:0][panel_pkg::DEBOUNCE_DEPTH-1:0] hist;

    logic menu_pending;
    logic other_pressed;
    logic menu_press;
    logic menu_release;
    logic step_allowed;

    assign tracked = {btn_sync.right, btn_sync.left, btn_sync.menu};

    // Anything but menu held down cancels a tap
    assign other_pressed = ~&{btn_sync.a, btn_sync.b, btn_sync.up, btn_sync.down,
                              btn_sync.left, btn_sync.right, btn_sync.sel, btn_sync.start};

    assign menu_press   = hist[MENU] == panel_pkg::PRESS_PATTERN;
    assign menu_release = hist[MENU] == panel_pkg::RELEASE_PATTERN;
    assign step_allowed = menu_disabled & btn_sync.menu;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_meta <= '1; // All released
            btn_sync <= '1;
            hist     <= '1;
        end else begin
            btn_meta <= buttons;
            btn_sync <= btn_meta;
            for (int i = 0; i < 3; i++) begin
                hist[i] <= {hist[i][panel_pkg::DEBOUNCE_DEPTH-2:0], tracked[i]};
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            menu_disabled <= 1'b1;
            menu_pending  <= 1'b0;
        end else begin
            if (menu_press) begin
                menu_pending <= 1'b1;
            end
            if (menu_release && menu_pending) begin
                menu_disabled <= ~menu_disabled;
                menu_pending  <= 1'b0;
            end
            if (other_pressed) begin
                menu_pending <= 1'b0; // Wins over a same-cycle press
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bright_up   <= 1'b0;
            bright_down <= 1'b0;
        end else begin
            bright_up   <= step_allowed && hist[RIGHT] == panel_pkg::PRESS_PATTERN;
            bright_down <= step_allowed && hist[LEFT] == panel_pkg::PRESS_PATTERN;
        end
    end

endmodule

// ==== panel/backlight_ctrl.sv ====
// Step strobes are taken as already qualified; PWM stays off until LCD init and first half second
`timescale 1ns/1ps

module backlight_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic bright_up,
    input  logic bright_down,
    input  logic lcd_init_done,
    input  logic half_second_ena,
    output logic lcd_pwm
);

    panel_pkg::brightness_t brightness;
    panel_pkg::pwm_count_t  pwm_cnt;
    panel_pkg::pwm_count_t  duty_limit;
    logic                   bl_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            brightness <= panel_pkg::BRIGHT_RESET;
        end else if (bright_up && brightness != panel_pkg::BRIGHT_MAX) begin
            brightness <= brightness + 4'd1;
        end else if (bright_down && brightness != 4'd0) begin
            brightness <= brightness - 4'd1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bl_ready <= 1'b0;
        end else if (half_second_ena) begin
            bl_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_cnt <= '0;
        end else if (pwm_cnt == panel_pkg::PWM_LAST) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 9'd1;
        end
    end

    // Level 0 still gives one high cycle per period
    assign duty_limit = panel_pkg::pwm_count_t'({brightness, 4'd0});
    assign lcd_pwm    = lcd_init_done & bl_ready & (pwm_cnt <= duty_limit);

endmodule

// ==== power/battery_sampler.sv ====
// ADC_INTERVAL must fit in 16 bits; a sample arriving on the publish cycle starts the next block
`timescale 1ns/1ps

module battery_sampler #(
    parameter int ADC_INTERVAL = power_pkg::ADC_INTERVAL_CYCLES
) (
    input  logic                   clk,
    input  logic                   reset,
    input  power_pkg::adc_sample_t adc_sample,
    output logic                   adc_req,
    output power_pkg::volt_t       volt,
    output logic                   volt_valid
);

    power_pkg::adc_timer_t  adc_timer;
    power_pkg::volt_sum_t   volt_sum;
    power_pkg::sample_cnt_t volt_cnt;
    power_pkg::volt_sum_t   sample_ext;

    assign sample_ext = power_pkg::volt_sum_t'(adc_sample.value);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            adc_timer <= '0;
            adc_req   <= 1'b0;
        end else if (adc_timer == power_pkg::adc_timer_t'(ADC_INTERVAL)) begin
            adc_timer <= '0;
            adc_req   <= 1'b1;
        end else begin
            adc_timer <= adc_timer + 16'd1;
            adc_req   <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            volt_sum   <= '0;
            volt_cnt   <= '0;
            volt       <= '0;
            volt_valid <= 1'b0;
        end else begin
            volt_valid <= 1'b0;
            if (volt_cnt[power_pkg::AVG_SAMPLES_LOG2]) begin // 256 collected
                volt       <= volt_sum[21:power_pkg::AVG_SAMPLES_LOG2];
                volt_valid <= 1'b1;
                volt_sum   <= adc_sample.valid ? sample_ext : '0;
                volt_cnt   <= power_pkg::sample_cnt_t'(adc_sample.valid);
            end else if (adc_sample.valid) begin
                volt_sum <= volt_sum + sample_ext;
                volt_cnt <= volt_cnt + 9'd1;
            end
        end
    end

endmodule

// ==== power/battery_indicator.sv ====
// Lithium thresholds only; LEDs follow the last published average, not each sample
`timescale 1ns/1ps

module battery_indicator (
    input  logic                     clk,
    input  logic                     reset,
    input  power_pkg::volt_t         volt,
    input  logic [7:0]               pmic_status,
    input  logic                     second_ena,
    output power_pkg::battery_leds_t leds
);

    logic                     blink;
    power_pkg::battery_leds_t leds_next;

    always_comb begin
        leds_next = '0;
        if (volt >= power_pkg::VOLT_VALID) begin
            if (pmic_status[power_pkg::PMIC_CHARGING_BIT]) begin
                leds_next.white = volt < power_pkg::VOLT_FULL; // Lit while charging below full
            end else if (volt < power_pkg::VOLT_RED) begin
                leds_next.low_battery = 1'b1;
                leds_next.red         = blink;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            blink <= 1'b0;
            leds  <= '0;
        end else begin
            if (second_ena) begin
                blink <= ~blink;
            end
            leds <= leds_next;
        end
    end

endmodule

// ==== verilog/system_monitor.sv ====
// ADC_INTERVAL must fit in 16 bits; the averager's update pulse is not routed out
`timescale 1ns/1ps

module system_monitor #(
    parameter int ADC_INTERVAL = power_pkg::ADC_INTERVAL_CYCLES
) (
    input  logic                     clk,
    input  logic                     reset,
    input  panel_pkg::buttons_t      buttons,
    input  logic                     lcd_init_done,
    input  logic                     half_second_ena,
    input  logic                     second_ena,
    input  power_pkg::adc_sample_t   adc_sample,
    input  logic [7:0]               pmic_status,
    output logic                     menu_disabled,
    output logic                     lcd_pwm,
    output logic                     adc_req,
    output power_pkg::battery_leds_t leds
);

    logic             bright_up;
    logic             bright_down;
    power_pkg::volt_t volt;

    panel_input panel_input_inst (
        .clk           (clk),
        .reset         (reset),
        .buttons       (buttons),
        .menu_disabled (menu_disabled),
        .bright_up     (bright_up),
        .bright_down   (bright_down)
    );

    backlight_ctrl backlight_ctrl_inst (
        .clk             (clk),
        .reset           (reset),
        .bright_up       (bright_up),
        .bright_down     (bright_down),
        .lcd_init_done   (lcd_init_done),
        .half_second_ena (half_second_ena),
        .lcd_pwm         (lcd_pwm)
    );

    battery_sampler #(
        .ADC_INTERVAL (ADC_INTERVAL)
    ) battery_sampler_inst (
        .clk        (clk),
        .reset      (reset),
        .adc_sample (adc_sample),
        .adc_req    (adc_req),
        .volt       (volt),
        .volt_valid ()
    );

    battery_indicator battery_indicator_inst (
        .clk         (clk),
        .reset       (reset),
        .volt        (volt),
        .pmic_status (pmic_status),
        .second_ena  (second_ena),
        .leds        (leds)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// Free-running 8 ns clock that starts low and has no enable or stop
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk; // Half period
        end
    end

endmodule

// ==== sim/tb_system_monitor.sv ====
// ADC interval shortened to 63; inputs change on falling edges; stops at the first error
`timescale 1ns/1ps

module tb_system_monitor;

    localparam int PWM_PERIOD = 449;
    localparam int WAIT_LIMIT = 1000;

    // Active-low sets from bit 8 menu down to bit 0 start
    localparam panel_pkg::buttons_t RELEASED    = 9'h1ff;
    localparam panel_pkg::buttons_t MENU_DOWN   = 9'h0ff;
    localparam panel_pkg::buttons_t LEFT_DOWN   = 9'h1df;
    localparam panel_pkg::buttons_t RIGHT_DOWN  = 9'h1ef;
    localparam panel_pkg::buttons_t MENU_A_DOWN = 9'h0f7;

    logic                     clk;
    logic                     reset;
    panel_pkg::buttons_t      buttons;
    logic                     lcd_init_done;
    logic                     half_second_ena;
    logic                     second_ena;
    power_pkg::adc_sample_t   adc_sample;
    logic [7:0]               pmic_status;
    logic                     menu_disabled;
    logic                     lcd_pwm;
    logic                     adc_req;
    power_pkg::battery_leds_t leds;

    int               seed;
    power_pkg::volt_t model_volt;
    logic             model_blink;
    logic             check_en;
    logic [22:0]      led_key;
    logic [22:0]      led_key_prev;

    tb_clock_gen clock_gen_inst (.clk(clk));

    system_monitor #(
        .ADC_INTERVAL (63)
    ) system_monitor_inst (
        .clk             (clk),
        .reset           (reset),
        .buttons         (buttons),
        .lcd_init_done   (lcd_init_done),
        .half_second_ena (half_second_ena),
        .second_ena      (second_ena),
        .adc_sample      (adc_sample),
        .pmic_status     (pmic_status),
        .menu_disabled   (menu_disabled),
        .lcd_pwm         (lcd_pwm),
        .adc_req         (adc_req),
        .leds            (leds)
    );

    function automatic power_pkg::battery_leds_t expected_leds(input power_pkg::volt_t volt,
                                                               input logic [7:0] status,
                                                               input logic blink);
        power_pkg::battery_leds_t result;
        logic present;
        logic charging;
        present            = volt >= power_pkg::VOLT_VALID;
        charging           = status[power_pkg::PMIC_CHARGING_BIT];
        result.white       = present && charging && volt < power_pkg::VOLT_FULL;
        result.low_battery = present && !charging && volt < power_pkg::VOLT_RED;
        result.red         = result.low_battery && blink; // Blinks only when low
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic wait_adc_req(output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("adc_req never pulsed");
            end
        end while (!adc_req);
    endtask

    task automatic send_sample(input power_pkg::volt_t value);
        int waited;
        wait_adc_req(waited);
        adc_sample.valid = 1'b1;
        adc_sample.value = value;
        @(negedge clk);
        adc_sample.valid = 1'b0;
    endtask

    task automatic send_block(input power_pkg::volt_t value);
        for (int i = 0; i < 255; i++) begin
            send_sample(value);
        end
        check_en = 1'b0; // Average lands two cycles after the last sample
        send_sample(value);
        repeat (2) @(negedge clk);
        model_volt = value;
        check_en   = 1'b1;
    endtask

    task automatic pulse_second();
        second_ena = 1'b1;
        @(negedge clk);
        second_ena  = 1'b0;
        model_blink = ~model_blink; // Blink flop has flipped by now
        repeat (4) @(negedge clk);
    endtask

    task automatic hold_buttons(input panel_pkg::buttons_t level, input int cycles);
        buttons = level;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic tap_button(input panel_pkg::buttons_t level);
        hold_buttons(level, 30);
        hold_buttons(RELEASED, 30);
    endtask

    task automatic check_duty(input int level);
        int   high;
        int   guard;
        logic prev;
        guard = 0;
        prev  = lcd_pwm;
        @(negedge clk);
        while (!(lcd_pwm && !prev)) begin
            guard++;
            if (guard > 2 * PWM_PERIOD) begin
                report_timeout("lcd_pwm never rose");
            end
            prev = lcd_pwm;
            @(negedge clk);
        end
        high = 0;
        repeat (PWM_PERIOD) begin
            if (lcd_pwm) begin
                high++;
            end
            @(negedge clk);
        end
        check_value("lcd_pwm high cycles", 32'(high), 32'(16 * level + 1));
    endtask

    // Skips the cycle right after the model inputs move
    always @(posedge clk) begin
        led_key = {model_volt, pmic_status, model_blink};
        if (check_en && led_key == led_key_prev) begin
            check_value("leds", 32'(leds), 32'(expected_leds(model_volt, pmic_status, model_blink)));
        end
        led_key_prev = led_key;
    end

    initial begin
        int               taps;
        int               gap;
        int               model_bright;
        logic             charging;
        power_pkg::volt_t value;
        power_pkg::volt_t boundary [6];

        seed            = 32'hfca0a172;
        boundary        = '{14'd699, 14'd700, 14'd1181, 14'd1182, 14'd1422, 14'd1423};
        reset           = 1'b1;
        buttons         = RELEASED;
        lcd_init_done   = 1'b0;
        half_second_ena = 1'b0;
        second_ena      = 1'b0;
        adc_sample      = '0;
        pmic_status     = '0;
        model_volt      = '0;
        model_blink     = 1'b0;
        check_en        = 1'b0;
        led_key_prev    = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_value("menu_disabled", 32'(menu_disabled), 32'd1);
        check_value("lcd_pwm", 32'(lcd_pwm), 32'd0);
        check_value("adc_req", 32'(adc_req), 32'd0);
        check_value("leds", 32'(leds), 32'd0);
        check_en = 1'b1;

        tap_button(MENU_DOWN);
        check_value("menu_disabled", 32'(menu_disabled), 32'd0);
        tap_button(MENU_DOWN);
        check_value("menu_disabled", 32'(menu_disabled), 32'd1);
        hold_buttons(MENU_DOWN, 24); // Press recognized by now
        hold_buttons(MENU_A_DOWN, 4);
        hold_buttons(MENU_DOWN, 4);
        hold_buttons(RELEASED, 30);
        check_value("menu_disabled", 32'(menu_disabled), 32'd1);

        lcd_init_done   = 1'b1;
        half_second_ena = 1'b1;
        @(negedge clk);
        half_second_ena = 1'b0;
        model_bright    = 3;
        check_duty(model_bright);
        for (int round = 0; round < 4; round++) begin
            if (round < 2) begin
                taps = 16 + int'($unsigned($random(seed)) % 4); // Runs past either end
            end else begin
                taps = 1 + int'($unsigned($random(seed)) % 14);
            end
            for (int t = 0; t < taps; t++) begin
                if (round % 2 == 0) begin
                    tap_button(RIGHT_DOWN);
                    model_bright = (model_bright == 15) ? 15 : model_bright + 1;
                end else begin
                    tap_button(LEFT_DOWN);
                    model_bright = (model_bright == 0) ? 0 : model_bright - 1;
                end
            end
            check_duty(model_bright);
        end
        tap_button(MENU_DOWN);
        check_value("menu_disabled", 32'(menu_disabled), 32'd0);
        repeat (3) tap_button(RIGHT_DOWN);
        tap_button(LEFT_DOWN);
        check_duty(model_bright);
        tap_button(MENU_DOWN);
        check_value("menu_disabled", 32'(menu_disabled), 32'd1);

        wait_adc_req(gap);
        @(negedge clk);
        check_value("adc_req", 32'(adc_req), 32'd0); // One-cycle pulse
        wait_adc_req(gap);
        check_value("adc_req spacing", 32'(gap + 1), 32'd64);

        charging = 1'b0;
        for (int block = 0; block < 10; block++) begin
            if (block < 6) begin
                value = boundary[block];
            end else begin
                value = power_pkg::volt_t'(600 + $unsigned($random(seed)) % 901);
            end
            send_block(value);
            pulse_second();
            pulse_second();
            charging    = ~charging;
            pmic_status = 8'($random(seed));
            pmic_status[power_pkg::PMIC_CHARGING_BIT] = charging;
            pulse_second();
            pulse_second();
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
common/panel_pkg.sv
common/power_pkg.sv
panel/panel_input.sv
panel/backlight_ctrl.sv
power/battery_sampler.sv
power/battery_indicator.sv
verilog/system_monitor.sv
sim/tb_clock_gen.sv
sim/tb_system_monitor.sv

// ==== Makefile ====
TOP  := tb_system_monitor
SIM  := obj_dir/V$(TOP)
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --top-module $(TOP) -f compile.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
